//--- Makefile
# Verilator build and run for the mesh router testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module noc_router_tb
	./obj_dir/Vnoc_router_tb | tee /dev/stderr | grep "^No errors$$"

clean:
	rm -rf obj_dir

//--- common/noc_pkg.sv
// ---------------------------------------------------------------------
// Shared constants for the mesh NoC router
// Mesh size, port numbering, packet field layout, input queue sizing
// ---------------------------------------------------------------------

package noc_pkg;

  // ---------------------------------------------------------------------
  // Router ports
  // ---------------------------------------------------------------------
  localparam int NUM_PORTS  = 5;  // Core plus four compass directions

  // Port indices, shared by inputs and outputs
  localparam int PORT_CORE  = 0;
  localparam int PORT_NORTH = 1;  // Towards smaller Y
  localparam int PORT_EAST  = 2;  // Towards larger X
  localparam int PORT_SOUTH = 3;  // Towards larger Y
  localparam int PORT_WEST  = 4;  // Towards smaller X

  // ---------------------------------------------------------------------
  // Mesh geometry
  // ---------------------------------------------------------------------
  localparam int MESH_X     = 4;  // Columns
  localparam int MESH_Y     = 4;  // Rows
  localparam int COORD_W    = 2;  // Holds 0..3 on each axis

  // ---------------------------------------------------------------------
  // Packet layout
  // ---------------------------------------------------------------------
  // Bits 15:14 destination X
  // Bits 13:12 destination Y
  // Bits 11:0  payload, opaque to the router
  localparam int PAYLOAD_W  = 12;
  localparam int PACKET_W   = 2 * COORD_W + PAYLOAD_W;  // 16 bits

  localparam int Y_DEST_LSB = PAYLOAD_W;                // Y field just above payload
  localparam int X_DEST_LSB = Y_DEST_LSB + COORD_W;     // X field at the top

  // ---------------------------------------------------------------------
  // Input queues
  // ---------------------------------------------------------------------
  localparam int FIFO_DEPTH = 4;                        // Entries per input port
  localparam int PTR_W      = $clog2(FIFO_DEPTH);       // Read and write pointer width

endpackage

//--- dv/noc_router_tb.sv
// ---------------------------------------------------------------------
// Directed testbench for the 5-port mesh router at position (1,2)
// Per-input send queues, per input/output expected queues, monitor
// Tests for routing, ordering, back-pressure, round-robin, random load
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module noc_router_tb;

  import noc_pkg::*;

  localparam int ROUTER_X   = 1;
  localparam int ROUTER_Y   = 2;
  localparam int SRC_W      = 3;  // Payload bits 11:9 hold the source input
  localparam int SEQ_W      = 9;  // Payload bits 8:0 hold a sequence number
  localparam int SRC_LSB    = SEQ_W;
  localparam int RAND_PKTS  = 300;
  // Routing 80, ordering 8, back-pressure depth+2, round-robin 4, random
  localparam int TOTAL_PKTS = 80 + 8 + (FIFO_DEPTH + 2) + 4 + RAND_PKTS;
  localparam int TIMEOUT_CYCLES = TOTAL_PKTS * NUM_PORTS + 200;

  logic clk;
  logic reset_n;

  logic [NUM_PORTS-1:0][PACKET_W-1:0] i_data;
  logic [NUM_PORTS-1:0]               i_data_val;
  logic [NUM_PORTS-1:0]               o_en;
  logic [NUM_PORTS-1:0][PACKET_W-1:0] o_data;
  logic [NUM_PORTS-1:0]               o_data_val;
  logic [NUM_PORTS-1:0]               i_en;

  // ---------------------------------------------------------------------
  // Model state
  // ---------------------------------------------------------------------
  logic [PACKET_W-1:0] tx_q  [NUM_PORTS][$];             // Waiting to be offered
  logic [PACKET_W-1:0] exp_q [NUM_PORTS][NUM_PORTS][$];  // [input][output]
  int                  log_src [NUM_PORTS][$];           // Sources seen per output
  int                  log_cyc [NUM_PORTS][$];           // Cycle of each delivery
  int                  rr_model [NUM_PORTS];             // Predicted arbiter pointers
  int                  acc_cnt  [NUM_PORTS];             // Packets taken per input
  logic [NUM_PORTS-1:0] en_seen;                         // o_en at the last falling edge
  logic [NUM_PORTS-1:0] en_req;                          // Downstream enable wanted
  logic                 rand_en;                         // Random i_en each cycle
  logic [SEQ_W-1:0]     seq_num;
  int                   err_cnt;
  int                   cycle_cnt;

  tb_clock_gen u_clk (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  noc_router #(
    .X_LOC (ROUTER_X),
    .Y_LOC (ROUTER_Y)
  ) u_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      err_cnt++;
      $display("[ERROR] %0t: %s, got %0h expected %0h", $time, what, got, expected);
    end
  endtask

  // X first, then Y; south is larger Y
  function automatic int xy_route(input int x, input int y);
    if (x > ROUTER_X) return PORT_EAST;
    if (x < ROUTER_X) return PORT_WEST;
    if (y > ROUTER_Y) return PORT_SOUTH;
    if (y < ROUTER_Y) return PORT_NORTH;
    return PORT_CORE;
  endfunction

  task automatic enqueue(input int src, input int x, input int y);
    logic [PACKET_W-1:0] pkt;
    pkt = '0;
    pkt[X_DEST_LSB +: COORD_W] = COORD_W'(x);
    pkt[Y_DEST_LSB +: COORD_W] = COORD_W'(y);
    pkt[SRC_LSB +: SRC_W]      = SRC_W'(src);
    pkt[SEQ_W-1:0]             = seq_num;
    seq_num = seq_num + 1'b1;
    tx_q[src].push_back(pkt);
    exp_q[src][xy_route(x, y)].push_back(pkt);  // Expected exit port
  endtask

  function automatic int tx_pending();
    int n;
    n = 0;
    for (int p = 0; p < NUM_PORTS; p++) n += tx_q[p].size();
    return n;
  endfunction

  function automatic int all_pending();
    int n;
    n = tx_pending();
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int q = 0; q < NUM_PORTS; q++) n += exp_q[p][q].size();
    end
    return n;
  endfunction

  task automatic wait_drain();
    do @(negedge clk); while (all_pending() != 0);  // Until every packet has been delivered
  endtask

  // ---------------------------------------------------------------------
  // Input driver on the rising edge
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (i_data_val[p] && en_seen[p]) begin  // Taken at this edge
        void'(tx_q[p].pop_front());
        acc_cnt[p]++;
      end
      if (reset_n && tx_q[p].size() > 0) begin
        i_data[p]     <= tx_q[p][0];
        i_data_val[p] <= 1'b1;
      end else begin
        i_data_val[p] <= 1'b0;
      end
    end
    i_en <= rand_en ? NUM_PORTS'($urandom) : en_req;
  end

  // ---------------------------------------------------------------------
  // Output monitor on the falling edge where outputs are settled
  // ---------------------------------------------------------------------
  always @(negedge clk) begin : monitor
    logic [PACKET_W-1:0] pkt;
    logic [PACKET_W-1:0] exp_pkt;
    int                  src;
    en_seen = o_en;
    if (reset_n) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (o_data_val[q]) begin
          pkt = o_data[q];
          src = int'(pkt[SRC_LSB +: SRC_W]);
          check_value(i_en[q], 1'b1, $sformatf("output %0d valid while disabled", q));
          if (src >= NUM_PORTS) begin
            err_cnt++;
            $display("Output %0d carried packet %h with a bad source field", q, pkt);
          end else if (exp_q[src][q].size() == 0) begin
            err_cnt++;
            $display("Output %0d delivered packet %h that nobody sent there", q, pkt);
          end else begin
            exp_pkt = exp_q[src][q].pop_front();
            check_value(pkt, exp_pkt, $sformatf("output %0d packet from input %0d", q, src));
            rr_model[q] = (src + 1) % NUM_PORTS;  // Winner goes last
            log_src[q].push_back(src);
            log_cyc[q].push_back(cycle_cnt);
          end
        end
      end
    end
  end

  // Cycle counter and run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, traffic never drained", TIMEOUT_CYCLES);
      $display("Run ended with %0d errors", err_cnt);
      $display("Errors found");
      $finish;
    end
  end

  // ---------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------
  task automatic verify_reset_state();
    @(negedge clk);
    check_value(o_data_val, '0, "o_data_val after reset");
    check_value(o_en, {NUM_PORTS{1'b1}}, "o_en after reset");
  endtask

  task automatic route_all_destinations();
    @(negedge clk);
    en_req = '1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int x = 0; x < MESH_X; x++) begin
        for (int y = 0; y < MESH_Y; y++) enqueue(p, x, y);
      end
    end
    wait_drain();
  endtask

  task automatic ordered_burst();
    @(negedge clk);
    for (int i = 0; i < 8; i++) enqueue(PORT_SOUTH, 1, 0);  // Burst heading north
    wait_drain();
  endtask

  task automatic backpressure_fill();
    int base;
    @(negedge clk);
    en_req[PORT_EAST] = 1'b0;
    base = acc_cnt[PORT_CORE];
    for (int i = 0; i < FIFO_DEPTH + 2; i++) enqueue(PORT_CORE, 3, 1);
    do begin
      @(negedge clk);
      check_value(o_data_val[PORT_EAST], 1'b0, "east valid while blocked");
    end while (o_en[PORT_CORE]);
    check_value(acc_cnt[PORT_CORE] - base, FIFO_DEPTH, "packets taken before o_en fell");
    repeat (2) begin  // Stays full while blocked
      @(negedge clk);
      check_value(o_en[PORT_CORE], 1'b0, "core o_en while full");
      check_value(o_data_val[PORT_EAST], 1'b0, "east valid while blocked");
    end
    en_req[PORT_EAST] = 1'b1;
    wait_drain();
  endtask

  task automatic round_robin_order();
    logic [NUM_PORTS-1:0] load_mask;
    int                   exp_order [$];
    int                   start_ptr;
    int                   cand;
    load_mask = '1;
    load_mask[PORT_EAST] = 1'b0;  // Every input except east
    @(negedge clk);
    en_req[PORT_EAST] = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (load_mask[p]) enqueue(p, 3, 3);
    end
    do @(negedge clk); while (tx_pending() != 0);  // All four heads waiting
    start_ptr = rr_model[PORT_EAST];
    for (int k = 0; k < NUM_PORTS; k++) begin
      cand = (start_ptr + k) % NUM_PORTS;
      if (load_mask[cand]) exp_order.push_back(cand);
    end
    log_src[PORT_EAST].delete();
    log_cyc[PORT_EAST].delete();
    en_req[PORT_EAST] = 1'b1;
    wait_drain();
    check_value(log_src[PORT_EAST].size(), exp_order.size(), "east grant count");
    for (int i = 0; i < exp_order.size() && i < log_src[PORT_EAST].size(); i++) begin
      check_value(log_src[PORT_EAST][i], exp_order[i], $sformatf("east grant %0d", i));
      if (i > 0) begin
        check_value(log_cyc[PORT_EAST][i] - log_cyc[PORT_EAST][i-1], 1, "grant spacing");
      end
    end
  endtask

  task automatic random_traffic();
    int p;
    @(negedge clk);
    rand_en = 1'b1;
    for (int n = 0; n < RAND_PKTS; n++) begin
      p = int'($urandom % NUM_PORTS);
      enqueue(p, int'($urandom % MESH_X), int'($urandom % MESH_Y));
      @(negedge clk);
    end
    rand_en = 1'b0;
    en_req  = '1;
    wait_drain();
  endtask

  // ---------------------------------------------------------------------
  // Run
  // ---------------------------------------------------------------------
  initial begin
    void'($urandom(19613));
    i_data     <= '0;
    i_data_val <= '0;
    i_en       <= '0;
    en_req     = '1;
    en_seen    = '0;
    rand_en    = 1'b0;
    seq_num    = '0;
    err_cnt    = 0;
    cycle_cnt  = 0;
    for (int q = 0; q < NUM_PORTS; q++) begin
      rr_model[q] = 0;  // Arbiters start at input 0
      acc_cnt[q]  = 0;
    end
    wait (reset_n === 1'b1);
    verify_reset_state();
    route_all_destinations();
    ordered_burst();
    backpressure_fill();
    round_robin_order();
    random_traffic();
    $display("Run ended with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- dv/tb_clock_gen.sv
// ---------------------------------------------------------------------
// Testbench clock and reset source
// 10 ns clock, synchronous active-low reset held for 3 cycles
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;  // 10 ns period
  end

  // Released on a rising edge, like any other driven input
  initial begin
    o_reset_n = 1'b0;
    repeat (3) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

//--- project.f
common/noc_pkg.sv
router/input_fifo.sv
router/route_calc.sv
router/switch_allocator.sv
router/noc_router.sv
dv/tb_clock_gen.sv
dv/noc_router_tb.sv

//--- router/input_fifo.sv
// ---------------------------------------------------------------------
// Input packet queue for one router port
// Circular buffer with read/write pointers and an occupancy count
// Head packet and head valid go to route calc and switch allocator
// o_en tells upstream there is room for another packet
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module input_fifo (
  input  logic                         clk,
  input  logic                         reset_n,

  // Upstream side
  input  logic [noc_pkg::PACKET_W-1:0] i_data,      // Packet from upstream
  input  logic                         i_data_val,  // Upstream has a packet
  output logic                         o_en,        // Space available

  // Switch side
  input  logic                         i_pop,       // Head consumed this cycle
  output logic [noc_pkg::PACKET_W-1:0] o_data,      // Head packet
  output logic                         o_data_val   // Head is valid
);

  import noc_pkg::*;

  // ---------------------------------------------------------------------
  // Storage and pointers
  // ---------------------------------------------------------------------
  logic [PACKET_W-1:0] mem [FIFO_DEPTH];  // Payload storage, no reset
  logic [PTR_W-1:0]    wr_ptr;            // Next free slot
  logic [PTR_W-1:0]    rd_ptr;            // Current head slot
  logic [PTR_W:0]      count;             // 0..FIFO_DEPTH entries held

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  assign full  = (count == FIFO_DEPTH);
  assign empty = (count == '0);

  assign wr_en = i_data_val && !full;  // Accept only when room
  assign rd_en = i_pop && !empty;      // Allocator only pops a valid head

  // ---------------------------------------------------------------------
  // Control state
  // ---------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Packet write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // ---------------------------------------------------------------------
  // Outputs
  // ---------------------------------------------------------------------
  assign o_data     = mem[rd_ptr];  // Head visible one cycle after the write
  assign o_data_val = !empty;
  assign o_en       = !full;        // Registered state only, no path from i_pop

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  // The allocator must only pop a head it saw as valid
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!reset_n)
    i_pop |-> !empty)
    else $error("input_fifo: pop while empty");

  a_count_bound: assert property (@(posedge clk) disable iff (!reset_n)
    count <= FIFO_DEPTH)
    else $error("input_fifo: count above depth");

endmodule

//--- router/noc_router.sv
// ---------------------------------------------------------------------
// Input-buffered 5-port mesh router, top level
// Five input FIFOs, five XY route calculators, one switch allocator
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module noc_router #(
  parameter int unsigned X_LOC = 0,  // Router column in the mesh
  parameter int unsigned Y_LOC = 0   // Router row in the mesh
) (
  input  logic clk,
  input  logic reset_n,

  // ---------------------------------------------------------------------
  // Upstream, index = core, north, east, south, west
  // ---------------------------------------------------------------------
  input  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::PACKET_W-1:0] i_data,
  input  logic [noc_pkg::NUM_PORTS-1:0]                        i_data_val,
  output logic [noc_pkg::NUM_PORTS-1:0]                        o_en,        // Room in FIFO

  // ---------------------------------------------------------------------
  // Downstream, same port order
  // ---------------------------------------------------------------------
  output logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::PACKET_W-1:0] o_data,
  output logic [noc_pkg::NUM_PORTS-1:0]                        o_data_val,
  input  logic [noc_pkg::NUM_PORTS-1:0]                        i_en         // Can accept
);

  import noc_pkg::*;

  // Between queues, route calcs and allocator
  logic [NUM_PORTS-1:0][PACKET_W-1:0]  head_data;  // FIFO heads
  logic [NUM_PORTS-1:0]                head_val;   // Head valid per input
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] out_req;    // [input][output] requests
  logic [NUM_PORTS-1:0]                pop;        // Head consumed per input

  // One queue and one route calc per input port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_input

    input_fifo u_fifo (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[p]),      // From upstream
      .i_data_val (i_data_val[p]),
      .o_en       (o_en[p]),        // Back to upstream
      .i_pop      (pop[p]),         // From allocator
      .o_data     (head_data[p]),
      .o_data_val (head_val[p])
    );

    // Destination fields taken straight from the head packet
    route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC)
    ) u_route (
      .i_x_dest     (head_data[p][X_DEST_LSB +: COORD_W]),
      .i_y_dest     (head_data[p][Y_DEST_LSB +: COORD_W]),
      .i_val        (head_val[p]),
      .o_output_req (out_req[p])
    );

  end

  // Arbitration, crossbar and pop strobes
  switch_allocator u_alloc (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_output_req (out_req),
    .i_data       (head_data),
    .i_en         (i_en),        // From downstream
    .o_pop        (pop),
    .o_data       (o_data),      // To downstream
    .o_data_val   (o_data_val)
  );

endmodule

//--- router/route_calc.sv
// ---------------------------------------------------------------------
// XY dimension-order route calculation
// Head packet destination to a one-hot output port request
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module route_calc #(
  parameter int unsigned X_LOC = 0,  // This router's column
  parameter int unsigned Y_LOC = 0   // This router's row
) (
  input  logic [noc_pkg::COORD_W-1:0]   i_x_dest,     // Destination column
  input  logic [noc_pkg::COORD_W-1:0]   i_y_dest,     // Destination row
  input  logic                          i_val,        // Head packet valid
  output logic [noc_pkg::NUM_PORTS-1:0] o_output_req  // One-hot, bit = output port
);

  import noc_pkg::*;

  logic [NUM_PORTS-1:0] off_mesh;  // Ports that lead out of the mesh here

  // X first, then Y, then deliver locally
  always_comb begin
    o_output_req = '0;
    if (i_val) begin
      if (i_x_dest > X_LOC)      o_output_req[PORT_EAST]  = 1'b1;
      else if (i_x_dest < X_LOC) o_output_req[PORT_WEST]  = 1'b1;
      else if (i_y_dest > Y_LOC) o_output_req[PORT_SOUTH] = 1'b1;  // Y grows southward
      else if (i_y_dest < Y_LOC) o_output_req[PORT_NORTH] = 1'b1;
      else                       o_output_req[PORT_CORE]  = 1'b1;  // Arrived
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  // Border ports of this position
  assign off_mesh[PORT_CORE]  = 1'b0;
  assign off_mesh[PORT_NORTH] = (Y_LOC == 0);
  assign off_mesh[PORT_EAST]  = (X_LOC == MESH_X - 1);
  assign off_mesh[PORT_SOUTH] = (Y_LOC == MESH_Y - 1);
  assign off_mesh[PORT_WEST]  = (X_LOC == 0);

  always_comb begin
    if (i_val) begin
      a_req_onehot: assert final ($onehot(o_output_req))
        else $error("route_calc: request not one-hot");
    end
    // Destinations inside the mesh never push a packet over the edge
    a_on_mesh: assert final ((o_output_req & off_mesh) == '0)
      else $error("route_calc: request points off the mesh");
  end

endmodule

//--- router/switch_allocator.sv
// ---------------------------------------------------------------------
// Switch allocator and crossbar
// One round-robin arbiter per output, gated by downstream enable
// One-hot grants steer packets, drive output valids, pop the FIFOs
// ---------------------------------------------------------------------

`timescale 1ns/1ps

module switch_allocator (
  input  logic                         clk,
  input  logic                         reset_n,

  // Requests, [input][output]
  input  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::NUM_PORTS-1:0] i_output_req,
  input  logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::PACKET_W-1:0]  i_data,  // Heads
  input  logic [noc_pkg::NUM_PORTS-1:0]                         i_en,    // Downstream ready

  output logic [noc_pkg::NUM_PORTS-1:0]                         o_pop,   // Per input
  output logic [noc_pkg::NUM_PORTS-1:0][noc_pkg::PACKET_W-1:0]  o_data,  // Per output
  output logic [noc_pkg::NUM_PORTS-1:0]                         o_data_val
);

  import noc_pkg::*;

  // ---------------------------------------------------------------------
  // Arbitration state
  // ---------------------------------------------------------------------
  logic [$clog2(NUM_PORTS)-1:0] rr_ptr  [NUM_PORTS];  // Highest-priority input per output
  logic [$clog2(NUM_PORTS)-1:0] nxt_ptr [NUM_PORTS];  // One past the winner

  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] req_col;  // [output][input], enable applied
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant;    // [output][input], one-hot or zero
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] grant_t;  // [input][output]

  // Transpose requests into per-output columns
  always_comb begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        req_col[q][p] = i_output_req[p][q] && i_en[q];  // Blocked output sees no requests
        grant_t[p][q] = grant[q][p];
      end
    end
  end

  // Cyclic search from each pointer
  always_comb begin
    logic [$clog2(NUM_PORTS)-1:0] cand;
    logic                         found;
    for (int q = 0; q < NUM_PORTS; q++) begin
      grant[q]   = '0;
      nxt_ptr[q] = rr_ptr[q];
      cand       = rr_ptr[q];
      found      = 1'b0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (!found && req_col[q][cand]) begin
          grant[q][cand] = 1'b1;
          nxt_ptr[q]     = (cand == NUM_PORTS - 1) ? '0 : cand + 1'b1;  // Winner drops to last
          found          = 1'b1;
        end
        cand = (cand == NUM_PORTS - 1) ? '0 : cand + 1'b1;
      end
    end
  end

  // Pointer moves only when the output actually granted
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        rr_ptr[q] <= '0;  // Input 0 first after reset
      end
    end else begin
      for (int q = 0; q < NUM_PORTS; q++) begin
        if (|grant[q]) begin
          rr_ptr[q] <= nxt_ptr[q];
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Crossbar and strobes
  // ---------------------------------------------------------------------
  always_comb begin
    for (int q = 0; q < NUM_PORTS; q++) begin
      o_data[q] = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (grant[q][p]) begin
          o_data[q] = o_data[q] | i_data[p];  // AND-OR mux, grant is one-hot
        end
      end
      o_data_val[q] = |grant[q];
    end
  end

  // Each input pops when any output took its head
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      o_pop[p] = |grant_t[p];
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  for (genvar g = 0; g < NUM_PORTS; g++) begin : g_chk
    a_grant_onehot: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(grant[g]))
      else $error("switch_allocator: output %0d multiple grants", g);

    // Relies on XY routing giving each head a single request
    a_single_output: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(grant_t[g]))
      else $error("switch_allocator: input %0d granted twice", g);
  end

endmodule
